// ==== logic/cachePkg.sv ====
/*
  Shared geometry and type definitions for the 4-way data cache.
  Addresses are word aligned; bits 1:0 are ignored.
  The set count comes from the setBits module parameter (4 to 10).
*/
package cachePkg;

  // Word and address widths
  localparam int DataWidth = 32;
  localparam int AddrWidth = 32;

  // Associativity
  localparam int NumWays = 4;

  // Eight words per line selected by address bits 4:2
  localparam int WordsPerLine = 8;
  localparam int WordSelWidth = 3;
  localparam int OffsetWidth  = 5;
  localparam int LineWidth    = WordsPerLine * DataWidth;

  // One age counter per way where 0 is least recently used
  localparam int AgeWidth = 2;

  // 128 sets unless the top level says otherwise
  localparam int DefaultSetBits = 7;

  typedef enum logic [1:0] {
    stIdle,
    stLookup,
    stResolve
  } ctrlState_t;

  // Both strobes together count as a write
  typedef enum logic {
    reqRead,
    reqWrite
  } reqKind_t;

endpackage

// ==== logic/cacheArrayIf.sv ====
`timescale 1ns/1ps

/*
  Bundle between the controller and the tag, line and age stores.
  Read data is registered in the stores; oldestWay is combinational.
*/
interface cacheArrayIf #(
  parameter int setBits = cachePkg::DefaultSetBits
);
  import cachePkg::*;

  localparam int TagWidth = AddrWidth - setBits - OffsetWidth;
  localparam int WayBits  = $clog2(NumWays);

  logic [setBits-1:0]   index;
  logic                 readEn;
  logic [NumWays-1:0]   tagWrEn;
  logic [NumWays-1:0]   lineWrEn;
  logic [TagWidth-1:0]  newTag;
  logic [LineWidth-1:0] newLine;
  logic [TagWidth-1:0]  tags [NumWays];
  logic [NumWays-1:0]   valids;
  logic [LineWidth-1:0] lines [NumWays];
  logic                 touchEn;
  logic [WayBits-1:0]   touchWay;
  logic [WayBits-1:0]   oldestWay;

  modport ctrl (
    output index, readEn, tagWrEn, lineWrEn, newTag, newLine, touchEn, touchWay,
    input  tags, valids, lines, oldestWay
  );
  modport tagPort  (input index, readEn, tagWrEn, newTag, output tags, valids);
  modport linePort (input index, readEn, lineWrEn, newLine, output lines);
  modport agePort  (input index, touchEn, touchWay, output oldestWay);

endinterface

// ==== logic/tagStore.sv ====
`timescale 1ns/1ps

/*
  Tag RAM per way plus valid flops per set and way.
  Valid bits clear on reset and are never cleared otherwise.
  Read data is registered and only updates while readEn is high.
*/
module tagStore #(
  parameter int setBits = cachePkg::DefaultSetBits
) (
  input  logic         clk,
  input  logic         resetn,
  cacheArrayIf.tagPort arr
);
  import cachePkg::*;

  localparam int TagWidth = AddrWidth - setBits - OffsetWidth;
  localparam int NumSets  = 1 << setBits;

  logic [NumSets-1:0][NumWays-1:0] validMem;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      validMem   <= '0;
      arr.valids <= '0;
    end else begin
      for (int w = 0; w < NumWays; w++) begin
        if (arr.tagWrEn[w]) begin
          validMem[arr.index][w] <= 1'b1;
        end
      end
      if (arr.readEn) begin
        arr.valids <= validMem[arr.index];
      end
    end
  end

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    logic [TagWidth-1:0] tagMem [NumSets];

    always_ff @(posedge clk) begin
      if (arr.tagWrEn[w]) begin
        tagMem[arr.index] <= arr.newTag;
      end
      if (arr.readEn) begin
        arr.tags[w] <= tagMem[arr.index];
      end
    end
  end

endmodule

// ==== logic/lineStore.sv ====
`timescale 1ns/1ps

/*
  One 256-bit line RAM per way, synchronous read and write.
  Contents are undefined until written; valid bits live in the tag store.
*/
module lineStore #(
  parameter int setBits = cachePkg::DefaultSetBits
) (
  input  logic          clk,
  cacheArrayIf.linePort arr
);
  import cachePkg::*;

  localparam int NumSets = 1 << setBits;

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    logic [LineWidth-1:0] lineMem [NumSets];

    // Only the way picked by the controller is written
    always_ff @(posedge clk) begin
      if (arr.lineWrEn[w]) begin
        lineMem[arr.index] <= arr.newLine;
      end
    end

    always_ff @(posedge clk) begin
      if (arr.readEn) begin
        arr.lines[w] <= lineMem[arr.index];
      end
    end
  end

endmodule

// ==== logic/replacementAges.sv ====
`timescale 1ns/1ps

/*
  True LRU ages, one 2-bit counter per set and way; 3 is newest, 0 oldest.
  Ages of a set are always a permutation of 0..3, starting at the way number.
  The read is combinational so the victim is known in the resolve cycle.
*/
module replacementAges #(
  parameter int setBits = cachePkg::DefaultSetBits
) (
  input  logic         clk,
  input  logic         resetn,
  cacheArrayIf.agePort arr
);
  import cachePkg::*;

  localparam int NumSets = 1 << setBits;
  localparam int WayBits = $clog2(NumWays);

  logic [NumWays-1:0][AgeWidth-1:0] ageMem [NumSets];
  logic [NumWays-1:0][AgeWidth-1:0] curAges;
  logic [NumWays-1:0][AgeWidth-1:0] nextAges;
  logic [AgeWidth-1:0]              touchedAge;

  assign curAges    = ageMem[arr.index];
  assign touchedAge = curAges[arr.touchWay];

  always_comb begin
    arr.oldestWay = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (curAges[w] == '0) begin
        arr.oldestWay = WayBits'(w);
      end
    end
  end

  // Ways younger than the touched one age by one, touched way becomes newest
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      if (w == arr.touchWay) begin
        nextAges[w] = '1;
      end else if (curAges[w] > touchedAge) begin
        nextAges[w] = curAges[w] - 1'b1;
      end else begin
        nextAges[w] = curAges[w];
      end
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int s = 0; s < NumSets; s++) begin
        for (int w = 0; w < NumWays; w++) begin
          ageMem[s][w] <= AgeWidth'(w);
        end
      end
    end else if (arr.touchEn) begin
      ageMem[arr.index] <= nextAges;
    end
  end

endmodule

// ==== logic/cacheController.sv ====
`timescale 1ns/1ps

/*
  Sequences one request over idle, lookup and resolve; oReady comes two
  clocks after the accepted strobe. Strobes outside idle are dropped.
  A write miss allocates without a memory fill: the new line is zero
  except the written word. No write-back of evicted lines.
*/
module cacheController #(
  parameter int setBits = cachePkg::DefaultSetBits
) (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           iRd,
  input  logic                           iWr,
  input  logic [cachePkg::AddrWidth-1:0] iAddr,
  input  logic [cachePkg::DataWidth-1:0] iData,
  output logic [cachePkg::DataWidth-1:0] oData,
  output logic                           oReady,
  output logic                           oHit,
  cacheArrayIf.ctrl                      arr
);
  import cachePkg::*;

  localparam int TagWidth = AddrWidth - setBits - OffsetWidth;
  localparam int WayBits  = $clog2(NumWays);
  localparam int ByteBits = OffsetWidth - WordSelWidth;

  ctrlState_t              state;
  reqKind_t                reqKind;
  logic [AddrWidth-1:0]    reqAddr;
  logic [DataWidth-1:0]    reqData;
  logic                    accept;
  logic [TagWidth-1:0]     reqTag;
  logic [setBits-1:0]      reqIndex;
  logic [WordSelWidth-1:0] reqWord;
  logic                    resolving;
  logic                    isWrite;
  logic [NumWays-1:0]      hitVec;
  logic                    hit;
  logic [WayBits-1:0]      hitWay;
  logic [WayBits-1:0]      victimWay;
  logic [WayBits-1:0]      writeWay;
  logic [LineWidth-1:0]    hitLine;
  logic [LineWidth-1:0]    mergedLine;
  logic [LineWidth-1:0]    fillLine;
  logic [DataWidth-1:0]    selWord;

  assign accept    = (state == stIdle) && (iRd || iWr);
  assign resolving = (state == stResolve);
  assign isWrite   = (reqKind == reqWrite);

  assign reqTag   = reqAddr[AddrWidth-1 -: TagWidth];
  assign reqIndex = reqAddr[OffsetWidth +: setBits];
  assign reqWord  = reqAddr[ByteBits +: WordSelWidth];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle: begin
          if (accept) begin
            state <= stLookup;
          end
        end
        stLookup: state <= stResolve;
        default:  state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= iAddr;
      reqData <= iData;
      reqKind <= iWr ? reqWrite : reqRead;
    end
  end

  always_comb begin
    hitWay = '0;
    for (int w = 0; w < NumWays; w++) begin
      hitVec[w] = arr.valids[w] && (arr.tags[w] == reqTag);
      if (hitVec[w]) begin
        hitWay = WayBits'(w);
      end
    end
  end

  assign hit = |hitVec;

  // Lowest invalid way wins, else the LRU way
  always_comb begin
    victimWay = arr.oldestWay;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!arr.valids[w]) begin
        victimWay = WayBits'(w);
      end
    end
  end

  assign hitLine = arr.lines[hitWay];
  assign selWord = hitLine[reqWord*DataWidth +: DataWidth];

  always_comb begin
    for (int i = 0; i < WordsPerLine; i++) begin
      if (i == reqWord) begin
        mergedLine[i*DataWidth +: DataWidth] = reqData;
        fillLine[i*DataWidth +: DataWidth]   = reqData;
      end else begin
        mergedLine[i*DataWidth +: DataWidth] = hitLine[i*DataWidth +: DataWidth];
        fillLine[i*DataWidth +: DataWidth]   = '0;
      end
    end
  end

  assign writeWay     = hit ? hitWay : victimWay;
  assign arr.index    = reqIndex;
  assign arr.readEn   = (state == stLookup);
  assign arr.newTag   = reqTag;
  assign arr.newLine  = hit ? mergedLine : fillLine;
  assign arr.tagWrEn  = (resolving && isWrite && !hit) ? (NumWays'(1) << victimWay) : '0;
  assign arr.lineWrEn = (resolving && isWrite) ? (NumWays'(1) << writeWay) : '0;
  // Read misses leave the ages alone
  assign arr.touchEn  = resolving && (hit || isWrite);
  assign arr.touchWay = writeWay;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      oReady <= 1'b0;
      oHit   <= 1'b0;
      oData  <= '0;
    end else begin
      oReady <= resolving;
      oHit   <= resolving && hit;
      oData  <= (resolving && hit && !isWrite) ? selWord : '0;
    end
  end

endmodule

// ==== logic/cacheTop.sv ====
`timescale 1ns/1ps

/*
  4-way set-associative data cache, 256-bit lines, no memory behind it.
  One request per strobe; oReady pulses two clocks later with oHit/oData.
  Give a new strobe no earlier than the cycle oReady is high.
*/
module cacheTop #(
  parameter int setBits = cachePkg::DefaultSetBits
) (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           iRd,
  input  logic                           iWr,
  input  logic [cachePkg::AddrWidth-1:0] iAddr,
  input  logic [cachePkg::DataWidth-1:0] iData,
  output logic [cachePkg::DataWidth-1:0] oData,
  output logic                           oReady,
  output logic                           oHit
);

  cacheArrayIf #(.setBits(setBits)) arrIf ();

  cacheController #(.setBits(setBits)) controllerInst (
    .clk    (clk),
    .resetn (resetn),
    .iRd    (iRd),
    .iWr    (iWr),
    .iAddr  (iAddr),
    .iData  (iData),
    .oData  (oData),
    .oReady (oReady),
    .oHit   (oHit),
    .arr    (arrIf.ctrl)
  );

  tagStore #(.setBits(setBits)) tagStoreInst (
    .clk    (clk),
    .resetn (resetn),
    .arr    (arrIf.tagPort)
  );

  lineStore #(.setBits(setBits)) lineStoreInst (
    .clk (clk),
    .arr (arrIf.linePort)
  );

  replacementAges #(.setBits(setBits)) agesInst (
    .clk    (clk),
    .resetn (resetn),
    .arr    (arrIf.agePort)
  );

endmodule

// ==== verification/cacheTbTasks.svh ====
/*
  Included inside cacheTb: address packing, the request driver, the value
  check and a reference model of tags, valids, line words and LRU ages.
  The model assumes the default set count.
*/
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

logic [TagW-1:0]      modelTag   [NumSets][NumWays];
logic                 modelValid [NumSets][NumWays];
logic [DataWidth-1:0] modelWord  [NumSets][NumWays][WordsPerLine];
int                   modelAge   [NumSets][NumWays];

function automatic logic [AddrWidth-1:0] makeAddr(input logic [TagW-1:0] tag,
    input logic [SetBits-1:0] setIdx, input logic [WordSelWidth-1:0] word);
  return {tag, setIdx, word, 2'b00};
endfunction

task automatic checkValue(input string name, input logic [DataWidth-1:0] got,
    input logic [DataWidth-1:0] expected);
  if (got !== expected) begin
    errorCount++;
    $display("Error %s got %h expected %h", name, got, expected);
    failRun($sformatf("Mismatch on %s at %0t ns", name, $time));
  end
endtask

task automatic modelReset();
  for (int s = 0; s < NumSets; s++) begin
    for (int w = 0; w < NumWays; w++) begin
      modelValid[s][w] = 1'b0;
      modelTag[s][w]   = '0;
      modelAge[s][w]   = w;
      for (int i = 0; i < WordsPerLine; i++) begin
        modelWord[s][w][i] = '0;
      end
    end
  end
endtask

// Younger ways than the touched one step down, touched way becomes newest
task automatic modelTouch(input int s, input int way);
  int oldAge;
  oldAge = modelAge[s][way];
  for (int w = 0; w < NumWays; w++) begin
    if (modelAge[s][w] > oldAge) begin
      modelAge[s][w]--;
    end
  end
  modelAge[s][way] = 3;
endtask

function automatic int modelVictim(input int s);
  for (int w = 0; w < NumWays; w++) begin
    if (!modelValid[s][w]) begin
      return w;
    end
  end
  for (int w = 0; w < NumWays; w++) begin
    if (modelAge[s][w] == 0) begin
      return w;
    end
  end
  return 0;
endfunction

task automatic modelAccess(input logic isWr, input logic [AddrWidth-1:0] addr,
    input logic [DataWidth-1:0] data, output logic [DataWidth-1:0] expData,
    output logic expHit);
  int              s;
  int              word;
  int              way;
  logic [TagW-1:0] tag;
  tag  = addr[AddrWidth-1 -: TagW];
  s    = addr[OffsetWidth +: SetBits];
  word = addr[2 +: WordSelWidth];
  way  = -1;
  for (int w = 0; w < NumWays; w++) begin
    if (modelValid[s][w] && modelTag[s][w] == tag) begin
      way = w;
    end
  end
  expHit  = (way >= 0);
  expData = '0;
  if (isWr) begin
    if (way < 0) begin
      way = modelVictim(s);
      modelTag[s][way]   = tag;
      modelValid[s][way] = 1'b1;
      for (int i = 0; i < WordsPerLine; i++) begin
        modelWord[s][way][i] = '0;
      end
    end
    modelWord[s][way][word] = data;
    modelTouch(s, way);
  end else if (way >= 0) begin
    expData = modelWord[s][way][word];
    modelTouch(s, way);
  end
endtask

// Called 2 ns after a rising edge; returns 2 ns after the ready edge
task automatic doAccess(input logic rd, input logic wr, input logic [AddrWidth-1:0] addr,
    input logic [DataWidth-1:0] data, output logic hitOut,
    output logic [DataWidth-1:0] dataOut);
  logic [DataWidth-1:0] expData;
  logic                 expHit;
  int                   edges;
  modelAccess(wr, addr, data, expData, expHit);
  iRd   = rd;
  iWr   = wr;
  iAddr = addr;
  iData = data;
  @(posedge clk);
  #2;
  iRd = 1'b0;
  iWr = 1'b0;
  checkValue("oReady", oReady, 0);
  edges = 0;
  while (!oReady && edges < ReadyLimit) begin
    @(posedge clk);
    #2;
    edges++;
  end
  if (!oReady) begin
    failRun("oReady did not rise after the request strobe");
  end
  checkValue("readyEdges", edges, 2);
  checkValue("oHit", oHit, expHit);
  checkValue("oData", oData, expData);
  hitOut  = oHit;
  dataOut = oData;
endtask

`endif

// ==== verification/cacheTb.sv ====
`timescale 1ns/1ps

/*
  Directed and random tests for the 4-way data cache at the default set count.
  Inputs change 2 ns after the rising edge and outputs are sampled there too.
  The first failing check ends the run.
*/
module cacheTb;
  import cachePkg::*;

  localparam int SetBits     = DefaultSetBits;
  localparam int TagW        = AddrWidth - SetBits - OffsetWidth;
  localparam int NumSets     = 1 << SetBits;
  localparam int ResetCycles = 10;
  localparam int ReadyLimit  = 8;

  // Requests issued by each test
  localparam int ResetReads  = 4;
  localparam int FillReqs    = 9;
  localparam int MergeReqs   = 9;
  localparam int EvictReqs   = 10;
  localparam int TouchReqs   = 11;
  localparam int RandomReqs  = 300;
  localparam int NumRequests = ResetReads + FillReqs + MergeReqs + EvictReqs + TouchReqs
                               + RandomReqs;
  localparam int TimeoutCycles = 3 * NumRequests * 3 + ResetCycles;

  localparam logic [TagW-1:0]    FillTag = 20'h12345;
  localparam logic [SetBits-1:0] FillSet = 7'd5;

  logic                 clk;
  logic                 resetn;
  logic                 iRd;
  logic                 iWr;
  logic [AddrWidth-1:0] iAddr;
  logic [DataWidth-1:0] iData;
  logic [DataWidth-1:0] oData;
  logic                 oReady;
  logic                 oHit;

  integer               seed;
  int                   errorCount = 0;
  int                   cycleCount = 0;
  logic [DataWidth-1:0] fillWord;

  cacheTop #(.setBits(SetBits)) cacheTop_inst (
    .clk    (clk),
    .resetn (resetn),
    .iRd    (iRd),
    .iWr    (iWr),
    .iAddr  (iAddr),
    .iData  (iData),
    .oData  (oData),
    .oReady (oReady),
    .oHit   (oHit)
  );

  always #20 clk = ~clk;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  `include "cacheTbTasks.svh"

  task automatic testResetReads();
    logic                 hit;
    logic [DataWidth-1:0] rdata;
    for (int i = 0; i < ResetReads; i++) begin
      doAccess(1'b1, 1'b0, $random(seed), $random(seed), hit, rdata);
      checkValue("oHit", hit, 0);
      checkValue("oData", rdata, 0);
    end
  endtask

  task automatic testWriteFill();
    logic                 hit;
    logic [DataWidth-1:0] rdata;
    fillWord = $random(seed);
    doAccess(1'b0, 1'b1, makeAddr(FillTag, FillSet, 3), fillWord, hit, rdata);
    checkValue("oHit", hit, 0);
    for (int w = 0; w < WordsPerLine; w++) begin
      doAccess(1'b1, 1'b0, makeAddr(FillTag, FillSet, w), '0, hit, rdata);
      checkValue("oHit", hit, 1);
      checkValue("oData", rdata, (w == 3) ? fillWord : '0);
    end
  endtask

  task automatic testWriteMerge();
    logic                 hit;
    logic [DataWidth-1:0] rdata;
    logic [DataWidth-1:0] newWord;
    newWord = $random(seed);
    doAccess(1'b0, 1'b1, makeAddr(FillTag, FillSet, 6), newWord, hit, rdata);
    checkValue("oHit", hit, 1);
    for (int w = 0; w < WordsPerLine; w++) begin
      doAccess(1'b1, 1'b0, makeAddr(FillTag, FillSet, w), '0, hit, rdata);
      checkValue("oHit", hit, 1);
      checkValue("oData", rdata, (w == 3) ? fillWord : ((w == 6) ? newWord : '0));
    end
  endtask

  // Five tags into one set; the first one filled is the LRU way
  task automatic testEvictOrder();
    logic                 hit;
    logic [DataWidth-1:0] rdata;
    logic [DataWidth-1:0] words [5];
    for (int i = 0; i < 5; i++) begin
      words[i] = $random(seed);
      doAccess(1'b0, 1'b1, makeAddr(20'h100 + i, 7'd20, i), words[i], hit, rdata);
      checkValue("oHit", hit, 0);
    end
    for (int i = 0; i < 5; i++) begin
      doAccess(1'b1, 1'b0, makeAddr(20'h100 + i, 7'd20, i), '0, hit, rdata);
      checkValue("oHit", hit, (i != 0));
      checkValue("oData", rdata, (i != 0) ? words[i] : '0);
    end
  endtask

  // Touching the oldest line moves the victim to the next oldest
  task automatic testTouchVictim();
    logic                 hit;
    logic [DataWidth-1:0] rdata;
    for (int i = 0; i < 4; i++) begin
      doAccess(1'b0, 1'b1, makeAddr(20'h200 + i, 7'd33, 0), $random(seed), hit, rdata);
    end
    doAccess(1'b1, 1'b0, makeAddr(20'h200, 7'd33, 0), '0, hit, rdata);
    checkValue("oHit", hit, 1);
    doAccess(1'b0, 1'b1, makeAddr(20'h204, 7'd33, 0), $random(seed), hit, rdata);
    checkValue("oHit", hit, 0);
    for (int i = 0; i < 5; i++) begin
      doAccess(1'b1, 1'b0, makeAddr(20'h200 + i, 7'd33, 0), '0, hit, rdata);
      checkValue("oHit", hit, (i != 1));
    end
  endtask

  // Kind 0 reads, 1 writes, 2 raises both strobes
  task automatic testRandom();
    logic                 hit;
    logic [DataWidth-1:0] rdata;
    int                   kind;
    logic [TagW-1:0]      tag;
    logic [SetBits-1:0]   setIdx;
    for (int i = 0; i < RandomReqs; i++) begin
      kind   = $unsigned($random(seed)) % 3;
      tag    = 20'h300 + $unsigned($random(seed)) % 6;
      setIdx = 7'd60 + $unsigned($random(seed)) % 2;
      doAccess(kind != 1, kind != 0, makeAddr(tag, setIdx, $random(seed)), $random(seed),
               hit, rdata);
    end
  endtask

  initial begin
    seed   = 37;
    clk    = 1'b0;
    resetn = 1'b0;
    iRd    = 1'b0;
    iWr    = 1'b0;
    iAddr  = '0;
    iData  = '0;
    modelReset();
    repeat (ResetCycles) @(posedge clk);
    #2;
    resetn = 1'b1;
    @(posedge clk);
    #2;
    testResetReads();
    testWriteFill();
    testWriteMerge();
    testEvictOrder();
    testTouchVictim();
    testRandom();
    if (errorCount == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      failRun("Checks failed during the run");
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      failRun("Timeout: the tests did not finish within the cycle limit");
    end
  end

endmodule

// ==== filelist.f ====
+incdir+verification
logic/cachePkg.sv
logic/cacheArrayIf.sv
logic/tagStore.sv
logic/lineStore.sv
logic/replacementAges.sv
logic/cacheController.sv
logic/cacheTop.sv
verification/cacheTb.sv

// ==== Bender.yml ====
package:
  name: cache4way

sources:
  - logic/cachePkg.sv
  - logic/cacheArrayIf.sv
  - logic/tagStore.sv
  - logic/lineStore.sv
  - logic/replacementAges.sv
  - logic/cacheController.sv
  - logic/cacheTop.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cacheTb.sv
